/* source/histPkg.sv */
`default_nettype none

// event, address and count formats shared by the datapath
package histPkg;

    localparam int defPixels = 4;
    localparam int defBins   = 16;

    localparam int pixelBits = $clog2(defPixels);    // pixel index width
    localparam int timeBits  = 8;                    // raw time code from the front end
    localparam int binBits   = $clog2(defBins);      // top time bits that select a bin
    localparam int addrBits  = pixelBits + binBits;
    localparam int countBits = 8;

    typedef struct packed {
        logic [pixelBits-1:0] pixel;
        logic [timeBits-1:0]  timeCode;
    } photonEvent_t;

    typedef logic [addrBits-1:0]  binAddr_t;   // {pixel, timeCode msbs}
    typedef logic [countBits-1:0] count_t;

    typedef struct packed {
        binAddr_t addr;
    } readReq_t;

    localparam count_t countMax = '1;

    // holds at full scale instead of wrapping
    function automatic count_t satIncrement(input count_t c);
        satIncrement = (c == countMax) ? c : c + count_t'(1);
    endfunction

endpackage

`default_nettype wire

/* source/ctrlPkg.sv */
`default_nettype none

// control vocabulary of the histogram engine
package ctrlPkg;

    typedef enum logic [2:0] {
        clearing,   // zero sweep over the whole RAM
        waitEvent,  // idle, looks for readout or queued event
        fetch,      // issue RAM read of the event bin
        readWait,   // RAM data comes back
        writeBack,  // write incremented count
        readFetch,  // issue RAM read for a readout
        readHold    // ack raised, waiting for req to drop
    } updState_t;

endpackage

`default_nettype wire

/* source/eventCapture.sv */
`timescale 1ns/10ps
`default_nettype none

module eventCapture import histPkg::*; #(
    parameter int numPixels    = 4,
    parameter int binsPerPixel = 16
) (
    input  logic         clk,
    input  logic         res,
    input  logic         evReq,
    input  photonEvent_t evData,
    output logic         evAck,
    input  logic         blocked,
    input  logic         full,
    output logic         push,
    output binAddr_t     pushData
);

    localparam int pixW = (numPixels > 1) ? $clog2(numPixels) : 1;
    localparam int binW = (binsPerPixel > 1) ? $clog2(binsPerPixel) : 1;

    binAddr_t evBin;
    logic     take;

    // pixel index on top, coarse time below
    assign evBin = binAddr_t'({evData.pixel[pixW-1:0], evData.timeCode[timeBits-1 -: binW]});

    // new request, room in the fifo and no sweep running
    assign take = evReq && !evAck && !full && !blocked;

    // evAck doubles as the handshake state
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evAck <= 1'b0;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;  // single cycle strobe
            if (!evAck) begin
                if (take) begin
                    push  <= 1'b1;
                    evAck <= 1'b1;
                end
            end else if (!evReq) begin
                evAck <= 1'b0;  // source has let go
            end
        end
    end

    // data is stable while req is high, so reload until accepted
    always_ff @(posedge clk) begin
        if (!evAck) begin
            pushData <= evBin;
        end
    end

endmodule

`default_nettype wire

/* source/eventFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module eventFifo import histPkg::*; #(
    parameter int fifoDepth = 8
) (
    input  logic     clk,
    input  logic     res,
    input  logic     push,
    input  binAddr_t pushData,
    input  logic     pop,
    output logic     full,
    output logic     empty,
    output binAddr_t popData
);

    localparam int ptrBits = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam int cntBits = $clog2(fifoDepth + 1);
    localparam logic [ptrBits-1:0] lastPtr = ptrBits'(fifoDepth - 1);

    binAddr_t           mem [fifoDepth];
    logic [ptrBits-1:0] wrPtr;
    logic [ptrBits-1:0] rdPtr;
    logic [cntBits-1:0] count;
    logic               doPush;
    logic               doPop;

    assign full    = (count == cntBits'(fifoDepth));
    assign empty   = (count == '0);
    assign popData = mem[rdPtr];  // head is visible without a pop

    // requests against a full or empty fifo are dropped
    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

`default_nettype wire

/* source/histRam.sv */
`timescale 1ns/10ps
`default_nettype none

module histRam import histPkg::*; #(
    parameter int numPixels    = 4,
    parameter int binsPerPixel = 16
) (
    input  logic     clk,
    input  logic     wrEn,
    input  binAddr_t wrAddr,
    input  count_t   wrData,
    input  logic     rdEn,
    input  binAddr_t rdAddr,
    output count_t   rdData
);

    localparam int numBins = numPixels * binsPerPixel;

    count_t mem [numBins];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read port, data one cycle after rdEn
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

/* source/histUpdater.sv */
`timescale 1ns/10ps
`default_nettype none

module histUpdater import histPkg::*, ctrlPkg::*; #(
    parameter int numPixels    = 4,
    parameter int binsPerPixel = 16
) (
    input  logic     clk,
    input  logic     res,
    input  logic     clear,
    input  logic     empty,
    input  binAddr_t popData,
    output logic     pop,
    output logic     blocked,
    output logic     ready,
    input  logic     rdReq,
    input  readReq_t rdAddr,
    output logic     rdAck,
    output count_t   rdData,
    output logic     wrEn,
    output binAddr_t wrAddr,
    output count_t   wrData,
    output logic     ramRdEn,
    output binAddr_t ramRdAddr,
    input  count_t   ramRdData
);

    localparam int       numBins = numPixels * binsPerPixel;
    localparam binAddr_t lastBin = binAddr_t'(numBins - 1);

    updState_t state;
    binAddr_t  sweepCnt;   // clear sweep address
    binAddr_t  curAddr;    // bin of the event in flight
    count_t    oldCount;
    logic      rdPending;

    assign rdPending = rdReq && !rdAck;

    // readouts win over queued events, clear wins over both
    assign pop = (state == waitEvent) && !rdPending && !empty && !clear;

    assign blocked = (state == clearing);
    assign ready   = (state == waitEvent) && empty;

    // RAM write port, shared by sweep and increment
    assign wrEn   = (state == clearing) || (state == writeBack);
    assign wrAddr = (state == clearing) ? sweepCnt : curAddr;
    assign wrData = (state == clearing) ? '0 : satIncrement(oldCount);

    // RAM read port, shared by update and readout
    assign ramRdEn   = (state == fetch) || (state == readFetch);
    assign ramRdAddr = (state == readFetch) ? rdAddr.addr : curAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= clearing;
            sweepCnt <= '0;
        end else if (clear) begin
            state    <= clearing;  // restart the sweep from bin 0
            sweepCnt <= '0;
        end else begin
            case (state)
                clearing: begin
                    sweepCnt <= sweepCnt + 1'b1;
                    if (sweepCnt == lastBin) begin
                        state <= waitEvent;
                    end
                end
                waitEvent: begin
                    if (rdPending) begin
                        state <= readFetch;
                    end else if (!empty) begin
                        state <= fetch;
                    end
                end
                fetch:     state <= readWait;
                readWait:  state <= writeBack;
                writeBack: state <= waitEvent;
                readFetch: state <= readHold;
                readHold: begin
                    if (rdAck && !rdReq) begin
                        state <= waitEvent;
                    end
                end
                default:   state <= clearing;
            endcase
        end
    end

    // readout ack, released only once the requester drops req
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdAck <= 1'b0;
        end else if ((state == readHold) && !rdAck) begin
            rdAck <= 1'b1;
        end else if (rdAck && !rdReq) begin
            rdAck <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            curAddr <= popData;
        end
        if (state == readWait) begin
            oldCount <= ramRdData;  // count before this event
        end
        if ((state == readHold) && !rdAck) begin
            rdData <= ramRdData;  // held for the whole ack phase
        end
    end

endmodule

`default_nettype wire

/* source/histTop.sv */
`timescale 1ns/10ps
`default_nettype none

module histTop import histPkg::*; #(
    parameter int numPixels    = 4,
    parameter int binsPerPixel = 16,
    parameter int fifoDepth    = 8
) (
    input  logic         clk,
    input  logic         res,
    input  logic         evReq,
    input  photonEvent_t evData,
    output logic         evAck,
    input  logic         clear,
    input  logic         rdReq,
    input  readReq_t     rdAddr,
    output logic         rdAck,
    output count_t       rdData,
    output logic         ready
);

    logic     push;
    logic     pop;
    logic     full;
    logic     empty;
    logic     blocked;
    binAddr_t pushData;
    binAddr_t popData;

    // RAM side of the updater
    logic     wrEn;
    logic     ramRdEn;
    binAddr_t wrAddr;
    binAddr_t ramRdAddr;
    count_t   wrData;
    count_t   ramRdData;

    eventCapture #(
        .numPixels    (numPixels),
        .binsPerPixel (binsPerPixel)
    ) eventCapture_i (
        .clk      (clk),
        .res      (res),
        .evReq    (evReq),
        .evData   (evData),
        .evAck    (evAck),
        .blocked  (blocked),
        .full     (full),
        .push     (push),
        .pushData (pushData)
    );

    eventFifo #(
        .fifoDepth (fifoDepth)
    ) eventFifo_i (
        .clk      (clk),
        .res      (res),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .full     (full),
        .empty    (empty),
        .popData  (popData)
    );

    histRam #(
        .numPixels    (numPixels),
        .binsPerPixel (binsPerPixel)
    ) histRam_i (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

    histUpdater #(
        .numPixels    (numPixels),
        .binsPerPixel (binsPerPixel)
    ) histUpdater_i (
        .clk       (clk),
        .res       (res),
        .clear     (clear),
        .empty     (empty),
        .popData   (popData),
        .pop       (pop),
        .blocked   (blocked),
        .ready     (ready),
        .rdReq     (rdReq),
        .rdAddr    (rdAddr),
        .rdAck     (rdAck),
        .rdData    (rdData),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .ramRdEn   (ramRdEn),
        .ramRdAddr (ramRdAddr),
        .ramRdData (ramRdData)
    );

endmodule

`default_nettype wire

/* tests/histTb.sv */
`timescale 1ns/10ps
`default_nettype none

module histTb import histPkg::*; ();

    localparam int numBins   = 64;     // 4 pixels x 16 bins
    localparam int maxCycles = 20000;  // ~600 events, 9 full readbacks of 64 bins, sweeps

    logic         clk;
    logic         res;
    logic         evReq;
    photonEvent_t evData;
    logic         evAck;
    logic         clear;
    logic         rdReq;
    readReq_t     rdAddr;
    logic         rdAck;
    count_t       rdData;
    logic         ready;

    count_t model [numBins];  // expected count per bin
    int     errors;
    int     checks;
    int     cycles = 0;
    int     lastWait;         // cycles the last event waited for ack
    logic   stallSeen;

    histTop histTop_i (
        .clk    (clk),
        .res    (res),
        .evReq  (evReq),
        .evData (evData),
        .evAck  (evAck),
        .clear  (clear),
        .rdReq  (rdReq),
        .rdAddr (rdAddr),
        .rdAck  (rdAck),
        .rdData (rdData),
        .ready  (ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == maxCycles) begin
            $display("timeout: design stopped responding");
            $display("summary: %0d checks, %0d errors", checks, errors);
            $display("test failed");
            $finish;
        end
    end

    // drive and sample just after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // pixel on top, top 4 time bits select the bin
    function automatic int binOf(input logic [1:0] pixel, input logic [7:0] timeCode);
        return int'(pixel) * 16 + int'(timeCode[7:4]);
    endfunction

    task automatic clearModel();
        for (int b = 0; b < numBins; b++) begin
            model[b] = '0;
        end
    endtask

    task automatic waitReady();
        tick();
        while (!ready) tick();
    endtask

    task automatic sendEvent(input logic [1:0] pixel, input logic [7:0] timeCode);
        int b;
        b = binOf(pixel, timeCode);
        evData.pixel    = pixel;
        evData.timeCode = timeCode;
        evReq    = 1'b1;
        lastWait = 0;
        tick();
        while (!evAck) begin
            lastWait++;
            tick();
        end
        if (lastWait > 0) stallSeen = 1'b1;
        if (model[b] != 8'hFF) model[b] = model[b] + 8'd1;  // saturate at 255
        evReq = 1'b0;
        tick();
        while (evAck) tick();
    endtask

    task automatic readRaw(input int b, output count_t value);
        rdAddr.addr = binAddr_t'(b);
        rdReq = 1'b1;
        tick();
        while (!rdAck) tick();
        value = rdData;
        tick();  // keep req up one more cycle
        checks++;
        if (!rdAck || rdData !== value) begin
            errors++;
            $display("CHECK FAILED at %0t: bin %0d ack or data changed while req high",
                     $time, b);
        end
        rdReq = 1'b0;
        tick();
        while (rdAck) tick();
    endtask

    task automatic readBin(input int b);
        count_t value;
        readRaw(b, value);
        checks++;
        if (value !== model[b]) begin
            errors++;
            $display("CHECK FAILED at %0t: bin %0d read %0d, expected %0d",
                     $time, b, value, model[b]);
        end
    endtask

    task automatic checkAll();
        for (int b = 0; b < numBins; b++) begin
            readBin(b);
        end
    endtask

    task automatic singleEvent(input logic [1:0] pixel, input logic [7:0] timeCode);
        sendEvent(pixel, timeCode);
        waitReady();
        checkAll();  // only the one bin may move
    endtask

    task automatic testResetZero();
        int waited;
        clearModel();
        waited = 0;
        while (!ready) begin
            tick();
            waited++;
        end
        checks++;
        if (waited != numBins) begin  // one sweep cycle per bin
            errors++;
            $display("CHECK FAILED at %0t: ready rose after %0d cycles, expected %0d",
                     $time, waited, numBins);
        end
        checkAll();
    endtask

    task automatic testSingleEvents();
        singleEvent(2'd0, 8'h00);
        singleEvent(2'd1, 8'h35);
        singleEvent(2'd2, 8'hF7);
        singleEvent(2'd3, 8'h9C);
    endtask

    task automatic testRandomBurst();
        logic [31:0] rnd;
        stallSeen = 1'b0;
        for (int i = 0; i < 200; i++) begin
            rnd = $urandom();
            sendEvent(rnd[9:8], rnd[7:0]);
        end
        checks++;
        if (!stallSeen) begin
            errors++;
            $display("ack was never held back during the random burst");
        end
        waitReady();
        checkAll();
    endtask

    task automatic testSaturation();
        count_t value;
        int     b;
        b = binOf(2'd2, 8'h5A);
        for (int i = 0; i < 300; i++) begin
            sendEvent(2'd2, 8'h5A);
        end
        waitReady();
        readRaw(b, value);
        checks++;
        if (value !== 8'd255) begin
            errors++;
            $display("CHECK FAILED at %0t: bin %0d read %0d, expected 255", $time, b, value);
        end
        checkAll();
    endtask

    task automatic testReadWhileQueued();
        count_t base;
        count_t value;
        int     b;
        b    = binOf(2'd1, 8'hE3);
        base = model[b];
        for (int i = 0; i < 12; i++) begin
            sendEvent(2'd1, 8'hE3);
        end
        checks++;
        if (ready) begin
            errors++;
            $display("CHECK FAILED at %0t: ready high while events are queued", $time);
        end
        readRaw(b, value);  // some events still in the fifo
        checks++;
        if (value < base || value > model[b]) begin
            errors++;
            $display("CHECK FAILED at %0t: bin %0d read %0d, outside %0d..%0d",
                     $time, b, value, base, model[b]);
        end
        waitReady();
        readBin(b);
        checkAll();
    endtask

    task automatic testClearThenEvents();
        waitReady();
        clear = 1'b1;
        tick();
        clear = 1'b0;
        clearModel();
        sendEvent(2'd3, 8'h10);
        checks++;
        if (lastWait < 60) begin
            errors++;
            $display("event was acked %0d cycles after clear, during the sweep", lastWait);
        end
        sendEvent(2'd3, 8'h10);
        sendEvent(2'd0, 8'hFF);
        waitReady();
        checkAll();
    endtask

    initial begin
        void'($urandom(6000));
        res       = 1'b0;
        evReq     = 1'b0;
        evData    = '0;
        clear     = 1'b0;
        rdReq     = 1'b0;
        rdAddr    = '0;
        errors    = 0;
        checks    = 0;
        lastWait  = 0;
        stallSeen = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;

        testResetZero();
        testSingleEvents();
        testRandomBurst();
        testSaturation();
        testReadWhileQueued();
        testClearThenEvents();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/histPkg.sv
source/ctrlPkg.sv
source/eventCapture.sv
source/eventFifo.sv
source/histRam.sv
source/histUpdater.sv
source/histTop.sv
tests/histTb.sv

/* run.sh */
#!/bin/sh
# build and run the histogram testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module histTb

./obj_dir/VhistTb | tee sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
